/* design/lsq_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Sizes, opcodes and bus structs shared by the load/store unit.
// Modules import it inside their body and use scoped names in ports.
//////////////////////////////////////////////////////////////////////

package lsq_pkg;

	localparam int data_width    = 64;	// Address and data word
	localparam int tag_width     = 6;	// 64 physical registers
	localparam int rob_idx_width = 5;
	localparam int queue_depth   = 8;	// Entries per queue, power of two
	localparam int age_width     = 5;	// Unique across both queues in flight
	localparam int ptr_width     = $clog2(queue_depth);
	localparam int count_width   = ptr_width + 1;

	localparam logic [5:0] op_ldq = 6'h29;
	localparam logic [5:0] op_stq = 6'h2d;
	localparam logic [5:0] op_lda = 6'h08;

	typedef enum logic [1:0] {
		mem_none,
		mem_load,
		mem_store,
		mem_lda
	} mem_op_t;

	typedef enum logic [1:0] {
		cmd_none,
		cmd_load,
		cmd_store
	} mem_command_t;

	// Value is only meaningful once ready, until then tag names the producer
	typedef struct packed {
		logic                  ready;
		logic [data_width-1:0] value;
		logic [tag_width-1:0]  tag;
	} operand_t;

	typedef struct packed {
		logic                     valid;
		logic [5:0]               opcode;
		logic [rob_idx_width-1:0] rob_idx;
		logic [tag_width-1:0]     dest_tag;
		operand_t                 base;
		logic [data_width-1:0]    displacement;
		operand_t                 data;	// Store data
	} dispatch_t;

	typedef struct packed {
		mem_op_t                  mem_op;
		logic [age_width-1:0]     age;
		logic [rob_idx_width-1:0] rob_idx;
		logic [tag_width-1:0]     dest_tag;
		operand_t                 base;
		logic [data_width-1:0]    displacement;
		operand_t                 data;
	} queued_t;

	typedef struct packed {
		logic                  valid;
		logic [tag_width-1:0]  tag;
		logic [data_width-1:0] value;
	} broadcast_t;

	typedef struct packed {
		logic                     valid;
		logic [rob_idx_width-1:0] rob_idx;
	} commit_t;

	typedef struct packed {
		logic                  valid;
		logic [data_width-1:0] address;
		logic [age_width-1:0]  age;
		logic [tag_width-1:0]  dest_tag;
	} load_head_t;

	// Pending marks a non-empty queue, age is then valid even before the store is ready
	typedef struct packed {
		logic                  valid;
		logic                  pending;
		logic [data_width-1:0] address;
		logic [data_width-1:0] data;
		logic [age_width-1:0]  age;
	} store_head_t;

	typedef struct packed {
		mem_command_t          command;
		logic [data_width-1:0] address;
		logic [data_width-1:0] data;
	} mem_request_t;

	typedef struct packed {
		logic                  valid;
		logic [data_width-1:0] data;
	} mem_response_t;

	// Age a was handed out before age b, wrap-around safe
	function automatic logic is_older(
		input logic [age_width-1:0] a,
		input logic [age_width-1:0] b
	);
		logic [age_width-1:0] diff;
		diff = a - b;
		return diff[age_width-1];
	endfunction

	// Operand after a broadcast with a matching tag
	function automatic operand_t wakeup(input operand_t operand, input broadcast_t broadcast);
		operand_t woken;
		woken = operand;
		if (broadcast.valid && !operand.ready && operand.tag == broadcast.tag) begin
			woken.ready = 1'b1;
			woken.value = broadcast.value;
		end
		return woken;
	endfunction

endpackage

/* design/lsq_dispatch.sv */
//////////////////////////////////////////////////////////////////////
// Front of the load/store unit. Decodes each dispatched instruction,
// stamps memory ops with an age and answers load-address directly.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsq_dispatch (
	input  logic                clock,
	input  logic                reset,
	input  lsq_pkg::dispatch_t  dispatch,
	output lsq_pkg::queued_t    entry,
	output lsq_pkg::broadcast_t lda_result
);
	import lsq_pkg::*;

	mem_op_t               mem_op;
	logic [age_width-1:0]  age;	// Age of the next load or store
	logic                  lda_valid;
	logic [tag_width-1:0]  lda_tag;
	logic [data_width-1:0] lda_value;

	always_comb begin
		mem_op = mem_none;
		if (dispatch.valid) begin
			case (dispatch.opcode)
				op_ldq:  mem_op = mem_load;
				op_stq:  mem_op = mem_store;
				op_lda:  mem_op = mem_lda;
				default: mem_op = mem_none;	// Not a memory op
			endcase
		end
	end

	assign entry = '{
		mem_op:       mem_op,
		age:          age,
		rob_idx:      dispatch.rob_idx,
		dest_tag:     dispatch.dest_tag,
		base:         dispatch.base,
		displacement: dispatch.displacement,
		data:         dispatch.data
	};

	always_ff @(posedge clock) begin
		if (reset) begin
			age <= '0;
		end else if (mem_op == mem_load || mem_op == mem_store) begin
			age <= age + 1'b1;
		end
	end

	// Load-address needs no memory, base arrives ready from rename
	always_ff @(posedge clock) begin
		if (reset) begin
			lda_valid <= 1'b0;
		end else begin
			lda_valid <= (mem_op == mem_lda);
		end
	end

	always_ff @(posedge clock) begin
		if (mem_op == mem_lda) begin
			lda_tag   <= dispatch.dest_tag;
			lda_value <= dispatch.base.value + dispatch.displacement;
		end
	end

	assign lda_result = '{valid: lda_valid, tag: lda_tag, value: lda_value};

endmodule

/* design/load_queue.sv */
//////////////////////////////////////////////////////////////////////
// Program-order ring of pending loads. Base operands are woken up from
// the broadcast bus; the oldest load is offered once its base is ready.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module load_queue (
	input  logic                clock,
	input  logic                reset,
	input  logic                flush,
	input  lsq_pkg::queued_t    entry,
	input  lsq_pkg::broadcast_t broadcast,
	input  logic                pop,
	output lsq_pkg::load_head_t head,
	output logic                full
);
	import lsq_pkg::*;

	operand_t               base [queue_depth];
	logic [data_width-1:0]  displacement [queue_depth];
	logic [age_width-1:0]   age [queue_depth];
	logic [tag_width-1:0]   dest_tag [queue_depth];

	logic [ptr_width-1:0]   head_ptr;	// Oldest load
	logic [ptr_width-1:0]   tail_ptr;	// Next free slot
	logic [count_width-1:0] count;
	logic                   push;

	assign full = (count == count_width'(queue_depth));
	assign push = (entry.mem_op == mem_load) && !full;	// Dropped when full

	//////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (push) begin
				tail_ptr <= tail_ptr + 1'b1;	// Wraps at queue_depth
			end
			if (pop) begin
				head_ptr <= head_ptr + 1'b1;
			end
			count <= count + count_width'(push) - count_width'(pop);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Entry storage with wakeup
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < queue_depth; i++) begin
			base[i] <= wakeup(base[i], broadcast);
		end
		// New entry catches a broadcast of the same cycle
		if (push) begin
			base[tail_ptr]         <= wakeup(entry.base, broadcast);
			displacement[tail_ptr] <= entry.displacement;
			age[tail_ptr]          <= entry.age;
			dest_tag[tail_ptr]     <= entry.dest_tag;
		end
	end

	always_comb begin
		head.valid    = (count != '0) && base[head_ptr].ready;
		head.address  = base[head_ptr].value + displacement[head_ptr];
		head.age      = age[head_ptr];
		head.dest_tag = dest_tag[head_ptr];
	end

endmodule

/* design/store_queue.sv */
//////////////////////////////////////////////////////////////////////
// Program-order ring of pending stores. Base and data wake up apart,
// a commit marks the store; the head is offered when both are set.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module store_queue (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  lsq_pkg::queued_t     entry,
	input  lsq_pkg::broadcast_t  broadcast,
	input  lsq_pkg::commit_t     commit,
	input  logic                 pop,
	output lsq_pkg::store_head_t head,
	output logic                 full
);
	import lsq_pkg::*;

	operand_t                 base [queue_depth];
	operand_t                 store_data [queue_depth];
	logic [data_width-1:0]    displacement [queue_depth];
	logic [age_width-1:0]     age [queue_depth];
	logic [rob_idx_width-1:0] rob_idx [queue_depth];
	logic [queue_depth-1:0]   committed;

	logic [queue_depth-1:0]   live;	// Slot holds a store
	logic [ptr_width-1:0]     head_ptr;
	logic [ptr_width-1:0]     tail_ptr;
	logic [count_width-1:0]   count;
	logic                     push;

	assign full = (count == count_width'(queue_depth));
	assign push = (entry.mem_op == mem_store) && !full;

	//////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
			live     <= '0;
		end else begin
			if (push) begin
				tail_ptr       <= tail_ptr + 1'b1;
				live[tail_ptr] <= 1'b1;
			end
			if (pop) begin
				head_ptr       <= head_ptr + 1'b1;
				live[head_ptr] <= 1'b0;
			end
			count <= count + count_width'(push) - count_width'(pop);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Entry storage, wakeup and commit marking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < queue_depth; i++) begin
			base[i]       <= wakeup(base[i], broadcast);
			store_data[i] <= wakeup(store_data[i], broadcast);
			if (commit.valid && live[i] && rob_idx[i] == commit.rob_idx) begin
				committed[i] <= 1'b1;
			end
		end
		if (push) begin
			base[tail_ptr]         <= wakeup(entry.base, broadcast);
			store_data[tail_ptr]   <= wakeup(entry.data, broadcast);
			displacement[tail_ptr] <= entry.displacement;
			age[tail_ptr]          <= entry.age;
			rob_idx[tail_ptr]      <= entry.rob_idx;
			committed[tail_ptr]    <= 1'b0;	// Commit comes later
		end
	end

	always_comb begin
		head.pending = live[head_ptr];	// Blocks younger loads even when not ready
		head.valid   = live[head_ptr] && base[head_ptr].ready
			&& store_data[head_ptr].ready && committed[head_ptr];
		head.address = base[head_ptr].value + displacement[head_ptr];
		head.data    = store_data[head_ptr].value;
		head.age     = age[head_ptr];
	end

endmodule

/* design/mem_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// Picks one memory request per cycle from the two queue heads,
// keeps the single outstanding load and returns its data as a result.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_arbiter (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   flush,
	input  lsq_pkg::load_head_t    load_head,
	input  lsq_pkg::store_head_t   store_head,
	input  lsq_pkg::mem_response_t mem_response,
	output lsq_pkg::mem_request_t  mem_request,
	output logic                   load_pop,
	output logic                   store_pop,
	output lsq_pkg::broadcast_t    load_result
);
	import lsq_pkg::*;

	logic                  outstanding;	// A load waits for memory
	logic                  squashed;	// Its response gets dropped
	logic [tag_width-1:0]  pending_tag;
	logic                  store_ahead;
	logic                  load_go;
	logic                  response_taken;
	logic                  result_valid;
	logic [tag_width-1:0]  result_tag;
	logic [data_width-1:0] result_value;

	// An older store, ready or not, holds the load back
	assign store_ahead    = store_head.pending && !is_older(load_head.age, store_head.age);
	assign load_go        = load_head.valid && !outstanding && !flush && !store_ahead;
	assign load_pop       = load_go;
	assign store_pop      = !load_go && store_head.valid;
	assign response_taken = mem_response.valid && outstanding;

	always_comb begin
		mem_request.command = cmd_none;
		mem_request.address = '0;
		mem_request.data    = '0;
		if (load_go) begin
			mem_request.command = cmd_load;
			mem_request.address = load_head.address;
		end else if (store_pop) begin
			mem_request.command = cmd_store;
			mem_request.address = store_head.address;
			mem_request.data    = store_head.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outstanding load tracking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding  <= 1'b0;
			squashed     <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			if (load_go) begin
				outstanding <= 1'b1;
			end else if (response_taken) begin
				outstanding  <= 1'b0;
				squashed     <= 1'b0;
				result_valid <= !squashed && !flush;
			end else if (flush) begin
				squashed <= outstanding;	// Still wait for the response, then drop it
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load_go) begin
			pending_tag <= load_head.dest_tag;
		end
		if (response_taken) begin
			result_tag   <= pending_tag;
			result_value <= mem_response.data;
		end
	end

	assign load_result = '{valid: result_valid, tag: result_tag, value: result_value};

endmodule

/* design/lsq_top.sv */
//////////////////////////////////////////////////////////////////////
// Load/store unit top. Dispatch feeds both queues side by side,
// the arbiter merges their heads onto the memory bus.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsq_top (
	input  logic                   clock,
	input  logic                   reset,
	input  lsq_pkg::dispatch_t     dispatch,
	input  lsq_pkg::broadcast_t    broadcast,
	input  lsq_pkg::commit_t       commit,
	input  logic                   mispredict,
	input  lsq_pkg::mem_response_t mem_response,
	output lsq_pkg::broadcast_t    lda_result,
	output lsq_pkg::broadcast_t    load_result,
	output lsq_pkg::mem_request_t  mem_request,
	output logic                   load_queue_full,
	output logic                   store_queue_full
);
	import lsq_pkg::*;

	queued_t     entry;
	load_head_t  load_head;
	store_head_t store_head;
	logic        load_pop;
	logic        store_pop;

	lsq_dispatch u_dispatch (
		.clock      (clock),
		.reset      (reset),
		.dispatch   (dispatch),
		.entry      (entry),
		.lda_result (lda_result)
	);

	load_queue u_load_queue (
		.clock     (clock),
		.reset     (reset),
		.flush     (mispredict),
		.entry     (entry),
		.broadcast (broadcast),
		.pop       (load_pop),
		.head      (load_head),
		.full      (load_queue_full)
	);

	store_queue u_store_queue (
		.clock     (clock),
		.reset     (reset),
		.flush     (mispredict),
		.entry     (entry),
		.broadcast (broadcast),
		.commit    (commit),
		.pop       (store_pop),
		.head      (store_head),
		.full      (store_queue_full)
	);

	mem_arbiter u_mem_arbiter (
		.clock        (clock),
		.reset        (reset),
		.flush        (mispredict),
		.load_head    (load_head),
		.store_head   (store_head),
		.mem_response (mem_response),
		.mem_request  (mem_request),
		.load_pop     (load_pop),
		.store_pop    (store_pop),
		.load_result  (load_result)
	);

endmodule

/* sim/lsq_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the load/store unit. Streams a random program from a
// fixed seed, answers loads from a memory model and checks every
// output against a program-order reference model.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsq_tb;
	import lsq_pkg::*;

	localparam int          program_length = 300;
	localparam int          reset_cycles   = 16;
	localparam int          clock_period   = 100;
	localparam int          max_broadcasts = 16;
	localparam logic [63:0] mem_base       = 64'h0000_0000_0001_0000;

	typedef struct packed {
		logic [tag_width-1:0]  tag;
		logic [data_width-1:0] addr;
		logic [data_width-1:0] value;
	} load_exp_t;

	typedef struct packed {
		logic [data_width-1:0] addr;
		logic [data_width-1:0] data;
	} store_exp_t;

	// Broadcasts still to send, load-address results still to see
	typedef struct packed {
		logic [31:0]           due;
		logic [tag_width-1:0]  tag;
		logic [data_width-1:0] value;
	} timed_value_t;

	typedef struct packed {
		logic [31:0]              due;
		logic [rob_idx_width-1:0] rob_idx;
		logic [31:0]              loads_before;	// Older loads that must finish first
	} commit_exp_t;

	logic          clock;
	logic          reset;
	dispatch_t     dispatch;
	broadcast_t    broadcast;
	commit_t       commit;
	logic          mispredict;
	mem_response_t mem_response;
	broadcast_t    lda_result;
	broadcast_t    load_result;
	mem_request_t  mem_request;
	logic          load_queue_full;
	logic          store_queue_full;

	load_exp_t    exp_loads[$];	// Dispatched, not yet requested
	load_exp_t    exp_results[$];	// Answered, result still to come
	store_exp_t   exp_stores[$];
	timed_value_t exp_lda[$];
	timed_value_t broadcasts[$];
	commit_exp_t  commits[$];
	logic [63:0]  ref_mem [16];	// Memory at the program point of dispatch
	logic [63:0]  retired_mem [16];	// Memory after the stores already sent
	logic [63:0]  memory [16];

	load_exp_t            in_flight;
	logic                 load_busy;
	logic                 load_squashed;
	logic                 last_was_load;
	logic                 last_was_store;
	logic [tag_width-1:0] next_tag;
	int                   response_due;
	int                   cycle;
	int                   dispatched;
	int                   loads_dispatched;
	int                   loads_retired;
	int                   stores_dispatched;
	int                   stores_seen;
	int                   commits_driven;
	int                   commits_prev;
	int                   commits_marked;	// Commits that took effect before the last cycle

	lsq_top dut (
		.clock            (clock),
		.reset            (reset),
		.dispatch         (dispatch),
		.broadcast        (broadcast),
		.commit           (commit),
		.mispredict       (mispredict),
		.mem_response     (mem_response),
		.lda_result       (lda_result),
		.load_result      (load_result),
		.mem_request      (mem_request),
		.load_queue_full  (load_queue_full),
		.store_queue_full (store_queue_full)
	);

	always #(clock_period / 2) clock = ~clock;

	// Initial memory word, distinct for every address
	function automatic logic [63:0] fill_word(input logic [63:0] addr);
		return {addr[31:0] ^ 32'h9e37_79b9, addr[63:32] ^ ~addr[31:0]};
	endfunction

	function automatic logic [63:0] word_address(input logic [3:0] word);
		return mem_base + {57'd0, word, 3'd0};
	endfunction

	function automatic logic [3:0] word_index(input logic [63:0] addr);
		return 4'((addr - mem_base) >> 3);
	endfunction

	function automatic logic drained();
		return exp_loads.size() == 0 && exp_results.size() == 0 && exp_stores.size() == 0
			&& exp_lda.size() == 0 && broadcasts.size() == 0 && commits.size() == 0
			&& !load_busy;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("Error at time %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_idle();
		check_value("mem_request.command", mem_request.command, cmd_none);
		check_value("lda_result.valid", lda_result.valid, 1'b0);
		check_value("load_result.valid", load_result.valid, 1'b0);
		check_value("load_queue_full", load_queue_full, 1'b0);
		check_value("store_queue_full", store_queue_full, 1'b0);
	endtask

	// Operand that is either ready now or woken by a later broadcast
	task automatic make_operand(input logic [63:0] value, output operand_t operand);
		timed_value_t pending;
		operand.value = value;
		operand.ready = 1'b1;
		operand.tag   = tag_width'($urandom);
		if (($urandom % 2) == 0 && broadcasts.size() < max_broadcasts) begin
			operand.ready = 1'b0;
			operand.tag   = next_tag;
			operand.value = {$urandom, $urandom};	// Garbage until woken
			pending.due   = cycle + $urandom % 5;
			pending.tag   = next_tag;
			pending.value = value;
			broadcasts.push_back(pending);
			next_tag++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Random program applied to the reference model in program order
	//////////////////////////////////////////////////////////////////////

	task automatic make_instruction(output dispatch_t d, output logic is_load,
			output logic is_store);
		int           kind;
		logic [3:0]   word;
		logic [63:0]  base_value;
		logic [63:0]  data_value;
		operand_t     base_op;
		operand_t     data_op;
		load_exp_t    ld;
		store_exp_t   st;
		timed_value_t lda;
		commit_exp_t  cm;
		d          = '0;
		is_load    = 1'b0;
		is_store   = 1'b0;
		kind       = $urandom % 16;
		word       = 4'($urandom % 16);
		base_value = {$urandom, $urandom};
		data_value = {$urandom, $urandom};
		if (kind < 6) begin
			if (load_queue_full || last_was_load) return;	// Full flag lags one push
			make_operand(base_value, base_op);
			d.valid        = 1'b1;
			d.opcode       = op_ldq;
			d.rob_idx      = rob_idx_width'($urandom);
			d.dest_tag     = tag_width'($urandom);
			d.base         = base_op;
			d.displacement = word_address(word) - base_value;
			ld.tag         = d.dest_tag;
			ld.addr        = word_address(word);
			ld.value       = ref_mem[word];
			exp_loads.push_back(ld);
			loads_dispatched++;
			is_load = 1'b1;
		end else if (kind < 11) begin
			if (store_queue_full || last_was_store) return;
			make_operand(base_value, base_op);
			make_operand(data_value, data_op);
			d.valid        = 1'b1;
			d.opcode       = op_stq;
			d.rob_idx      = rob_idx_width'(stores_dispatched);
			d.base         = base_op;
			d.displacement = word_address(word) - base_value;
			d.data         = data_op;
			st.addr        = word_address(word);
			st.data        = data_value;
			exp_stores.push_back(st);
			ref_mem[word]   = data_value;
			cm.due          = cycle + 1 + $urandom % 6;
			cm.rob_idx      = d.rob_idx;
			cm.loads_before = loads_dispatched;
			commits.push_back(cm);
			stores_dispatched++;
			is_store = 1'b1;
		end else if (kind < 14) begin
			d.valid        = 1'b1;
			d.opcode       = op_lda;
			d.dest_tag     = tag_width'($urandom);
			d.base.ready   = 1'b1;
			d.base.value   = base_value;
			d.displacement = data_value - base_value;	// Target address is data_value
			lda.due        = cycle + 2;
			lda.tag        = d.dest_tag;
			lda.value      = data_value;
			exp_lda.push_back(lda);
		end else begin
			d.valid  = 1'b1;
			d.opcode = 6'h10;	// Integer op for another unit
		end
		dispatched++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output checks on the values of the cycle just ended
	//////////////////////////////////////////////////////////////////////

	task automatic observe_outputs();
		load_exp_t    ld;
		store_exp_t   st;
		timed_value_t lda;
		if (exp_lda.size() != 0 && exp_lda[0].due == cycle) begin
			lda = exp_lda.pop_front();
			check_value("lda_result.valid", lda_result.valid, 1'b1);
			check_value("lda_result.tag", lda_result.tag, lda.tag);
			check_value("lda_result.value", lda_result.value, lda.value);
		end else begin
			check_value("lda_result.valid", lda_result.valid, 1'b0);
		end
		if (load_result.valid) begin
			if (exp_results.size() == 0) fail_run("A load result came out with no load pending");
			ld = exp_results.pop_front();
			check_value("load_result.tag", load_result.tag, ld.tag);
			check_value("load_result.value", load_result.value, ld.value);
			loads_retired++;
		end
		case (mem_request.command)
			cmd_none: begin
			end
			cmd_load: begin
				if (load_busy) begin
					fail_run("A load request was sent while another load was outstanding");
				end
				if (exp_loads.size() == 0) begin
					fail_run("A load request came out with no load queued");
				end
				ld = exp_loads.pop_front();
				check_value("mem_request.address", mem_request.address, ld.addr);
				in_flight     = ld;
				load_busy     = 1'b1;
				load_squashed = 1'b0;
				response_due  = cycle + $urandom % 4;
			end
			cmd_store: begin
				if (exp_stores.size() == 0) begin
					fail_run("A store request came out with no store queued");
				end
				if (stores_seen >= commits_marked) fail_run("A store was sent before its commit");
				st = exp_stores.pop_front();
				check_value("mem_request.address", mem_request.address, st.addr);
				check_value("mem_request.data", mem_request.data, st.data);
				memory[word_index(st.addr)]      = mem_request.data;
				retired_mem[word_index(st.addr)] = st.data;
				stores_seen++;
			end
			default: fail_run("The memory command has an illegal value");
		endcase
	endtask

	task automatic drive_inputs();
		dispatch_t     d;
		broadcast_t    b;
		commit_t       c;
		mem_response_t r;
		logic          flush;
		logic          is_load;
		logic          is_store;
		int            pick;
		d        = '0;
		b        = '0;
		c        = '0;
		r        = '0;
		is_load  = 1'b0;
		is_store = 1'b0;
		// Only while no committed store waits for memory
		flush = dispatched > 20 && dispatched < program_length
			&& commits_driven == stores_seen && ($urandom % 48) == 0;
		if (flush) begin
			exp_loads.delete();
			exp_stores.delete();
			commits.delete();
			if (load_busy) load_squashed = 1'b1;
			loads_retired = loads_dispatched - exp_results.size();
			ref_mem       = retired_mem;
		end
		if (load_busy && cycle >= response_due) begin
			r.valid = 1'b1;
			r.data  = memory[word_index(in_flight.addr)];
			if (!load_squashed) exp_results.push_back(in_flight);
			load_busy = 1'b0;
		end
		if (!flush && commits.size() != 0 && cycle >= commits[0].due
				&& loads_retired >= commits[0].loads_before) begin
			c.valid   = 1'b1;
			c.rob_idx = commits[0].rob_idx;
			void'(commits.pop_front());
			commits_driven++;
		end
		if (!flush && dispatched < program_length && ($urandom % 4) != 0) begin
			make_instruction(d, is_load, is_store);
		end
		pick = -1;
		for (int i = 0; i < broadcasts.size(); i++) begin
			if (pick < 0 && broadcasts[i].due <= cycle) pick = i;
		end
		if (pick >= 0) begin
			b.valid = 1'b1;
			b.tag   = broadcasts[pick].tag;
			b.value = broadcasts[pick].value;
			broadcasts.delete(pick);
		end
		last_was_load  = is_load;
		last_was_store = is_store;
		dispatch     <= d;
		broadcast    <= b;
		commit       <= c;
		mispredict   <= flush;
		mem_response <= r;
	endtask

	task automatic step();
		cycle++;
		commits_marked = commits_prev;
		commits_prev   = commits_driven;
		observe_outputs();
		drive_inputs();
	endtask

	initial begin
		void'($urandom(47));
		clock          = 1'b0;
		reset          = 1'b1;
		dispatch       = '0;
		broadcast      = '0;
		commit         = '0;
		mispredict     = 1'b0;
		mem_response   = '0;
		in_flight      = '0;
		load_busy      = 1'b0;
		load_squashed  = 1'b0;
		last_was_load  = 1'b0;
		last_was_store = 1'b0;
		next_tag       = '0;
		for (int i = 0; i < 16; i++) begin
			memory[i]      = fill_word(word_address(4'(i)));
			ref_mem[i]     = memory[i];
			retired_mem[i] = memory[i];
		end
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		repeat (4) begin
			@(posedge clock);
			cycle++;
			check_idle();
		end
		while (dispatched < program_length || !drained()) begin
			@(posedge clock);
			step();
		end
		repeat (8) begin	// Nothing stray may follow the last result
			@(posedge clock);
			step();
		end
		$display("RESULT: PASS");
		$finish;
	end

	initial begin
		#((reset_cycles + 40 * program_length) * clock_period);
		fail_run("Timeout: the program did not finish within the cycle limit");
	end

endmodule

/* verilog.f */
design/lsq_pkg.sv
design/lsq_dispatch.sv
design/load_queue.sv
design/store_queue.sv
design/mem_arbiter.sv
design/lsq_top.sv
sim/lsq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the load/store unit testbench with Verilator and runs it.
# The exit status is that of the simulation.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module lsq_tb \
	-f verilog.f \
	-Mdir obj_dir

./obj_dir/Vlsq_tb
